/* alu.sv */
`timescale 1ns/100ps

module alu (
    input  mipsPkg::aluOpT aluOp_i,
    input  logic [31:0]    a_i,
    input  logic [31:0]    b_i,
    input  logic [4:0]     sa_i,
    input  logic           isBeq_i,
    input  logic           isBne_i,
    output logic [31:0]    y_o,
    output logic           taken_o
);

    logic equal;

    always_comb begin
        case (aluOp_i)
            mipsPkg::aluAdd:   y_o = a_i + b_i;
            mipsPkg::aluSub:   y_o = a_i - b_i;
            mipsPkg::aluAnd:   y_o = a_i & b_i;
            mipsPkg::aluOr:    y_o = a_i | b_i;
            mipsPkg::aluSlt:   y_o = {31'h0, $signed(a_i) < $signed(b_i)};
            mipsPkg::aluSll:   y_o = b_i << sa_i;  // shifts rt
            mipsPkg::aluPassB: y_o = b_i;
            default:           y_o = 32'h0;
        endcase
    end

    // branch compare on its own, off the adder path
    assign equal   = (a_i == b_i);
    assign taken_o = (isBeq_i & equal) | (isBne_i & ~equal);

endmodule

/* datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic        clk,
    input  logic        rstN_i,
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instr_i,  // imem clocked on the opposite edge
    output logic        memEn_o,
    output logic        memWe_o,
    output logic [31:0] memAddr_o,
    output logic [31:0] memWdata_o,
    input  logic [31:0] memRdata_i,
    input  logic        memStall_i,
    output logic [31:0] debugWbPc_o,
    output logic        debugWbRfWen_o,
    output logic [4:0]  debugWbRfWnum_o,
    output logic [31:0] debugWbRfWdata_o
);

    mipsPkg::ifIdT  ifIdD, ifIdQ;
    mipsPkg::idExT  idExD, idExQ;
    mipsPkg::exMemT exMemD, exMemQ;
    mipsPkg::memWbT memWbD, memWbQ;

    logic stallF, stallD, stallE, stallM, stallW;
    logic flushD, flushE, flushM;
    logic [1:0] fwdA, fwdB;

    logic [31:0] pcF, pcPlus4F, pcNext;
    logic        fetchEn;

    logic [4:0]      rsD, rtD, rdD;
    logic [31:0]     rd1D, rd2D, immExtD, immD, jumpTargetD;
    mipsPkg::aluOpT  aluOpD;
    logic aluImmD, signExtD, regWeD, memReD, memWeD;
    logic isBeqD, isBneD, isJumpD, dstRtD;

    logic [31:0] srcAE, rtFwdE, srcBE, aluOutE;
    logic        takenE;
    logic [31:0] resultM;
    logic        rfWe;

    // EX operand select, same encoding as the hazard unit
    function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] regVal);
        case (sel)
            2'b01:   return resultM;
            2'b10:   return memWbQ.result;
            default: return regVal;
        endcase
    endfunction

    // IF
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcF     <= mipsPkg::resetPc;
            fetchEn <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
            if (!stallF) begin
                pcF <= pcNext;
            end
        end
    end

    assign pcPlus4F = pcF + 32'd4;

    always_comb begin
        if (takenE) pcNext = idExQ.branchTarget;  // branch in EX wins over jump in ID
        else if (isJumpD) pcNext = jumpTargetD;
        else pcNext = pcPlus4F;
    end

    assign instAddr_o = pcF;
    assign instEn_o   = fetchEn;

    always_comb begin
        ifIdD.instr   = instr_i;
        ifIdD.pc      = pcF;
        ifIdD.pcPlus4 = pcPlus4F;
    end

    pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallD), .flush_i(flushD),
        .d_i(ifIdD), .q_o(ifIdQ)
    );

    // ID
    assign rsD = ifIdQ.instr[25:21];
    assign rtD = ifIdQ.instr[20:16];
    assign rdD = ifIdQ.instr[15:11];

    mainDecoder decoder (
        .instr_i(ifIdQ.instr), .pcPlus4_i(ifIdQ.pcPlus4),
        .aluOp_o(aluOpD), .aluImm_o(aluImmD), .signExt_o(signExtD),
        .regWe_o(regWeD), .memRe_o(memReD), .memWe_o(memWeD),
        .isBeq_o(isBeqD), .isBne_o(isBneD), .isJump_o(isJumpD),
        .dstRt_o(dstRtD), .jumpTarget_o(jumpTargetD)
    );

    regFile rf (
        .clk(clk), .we_i(rfWe),
        .ra1_i(rsD), .ra2_i(rtD), .wa_i(memWbQ.dst),
        .wd_i(memWbQ.result),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    assign immExtD = signExtD ? {{16{ifIdQ.instr[15]}}, ifIdQ.instr[15:0]}
                              : {16'h0, ifIdQ.instr[15:0]};
    assign immD    = (aluOpD == mipsPkg::aluPassB) ? {ifIdQ.instr[15:0], 16'h0} : immExtD;  // lui

    always_comb begin
        idExD.pc           = ifIdQ.pc;
        idExD.pcPlus4      = ifIdQ.pcPlus4;
        idExD.rsVal        = rd1D;
        idExD.rtVal        = rd2D;
        idExD.imm          = immD;
        idExD.branchTarget = ifIdQ.pcPlus4 + {immExtD[29:0], 2'b00};
        idExD.sa           = ifIdQ.instr[10:6];
        idExD.rs           = rsD;
        idExD.rt           = rtD;
        idExD.dst          = dstRtD ? rtD : rdD;
        idExD.aluOp        = aluOpD;
        idExD.aluImm       = aluImmD;
        idExD.regWe        = regWeD && idExD.dst != 5'd0;  // $0 never written
        idExD.memRe        = memReD;
        idExD.memWe        = memWeD;
        idExD.isBeq        = isBeqD;
        idExD.isBne        = isBneD;
    end

    pipeReg #(.payloadT(mipsPkg::idExT)) idExReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallE), .flush_i(flushE),
        .d_i(idExD), .q_o(idExQ)
    );

    // EX
    assign srcAE  = fwdMux(fwdA, idExQ.rsVal);
    assign rtFwdE = fwdMux(fwdB, idExQ.rtVal);
    assign srcBE  = idExQ.aluImm ? idExQ.imm : rtFwdE;

    alu alu0 (
        .aluOp_i(idExQ.aluOp), .a_i(srcAE), .b_i(srcBE), .sa_i(idExQ.sa),
        .isBeq_i(idExQ.isBeq), .isBne_i(idExQ.isBne),
        .y_o(aluOutE), .taken_o(takenE)
    );

    always_comb begin
        exMemD.pc        = idExQ.pc;
        exMemD.aluOut    = aluOutE;
        exMemD.storeData = rtFwdE;  // forwarded rt for sw
        exMemD.dst       = idExQ.dst;
        exMemD.regWe     = idExQ.regWe;
        exMemD.memRe     = idExQ.memRe;
        exMemD.memWe     = idExQ.memWe;
    end

    pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallM), .flush_i(flushM),
        .d_i(exMemD), .q_o(exMemQ)
    );

    // MEM, held steady by the freeze while the memory stalls
    assign memEn_o    = exMemQ.memRe | exMemQ.memWe;
    assign memWe_o    = exMemQ.memWe;
    assign memAddr_o  = exMemQ.aluOut;
    assign memWdata_o = exMemQ.storeData;
    assign resultM    = exMemQ.memRe ? memRdata_i : exMemQ.aluOut;

    always_comb begin
        memWbD.pc     = exMemQ.pc;
        memWbD.result = resultM;
        memWbD.dst    = exMemQ.dst;
        memWbD.regWe  = exMemQ.regWe;
    end

    pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallW), .flush_i(1'b0),
        .d_i(memWbD), .q_o(memWbQ)
    );

    // WB, write lands on the last frozen cycle only
    assign rfWe = memWbQ.regWe & ~memStall_i;

    assign debugWbPc_o      = memWbQ.pc;
    assign debugWbRfWen_o   = rfWe;
    assign debugWbRfWnum_o  = memWbQ.dst;
    assign debugWbRfWdata_o = memWbQ.result;

    hazardUnit hazard (
        .rsD_i(rsD), .rtD_i(rtD),
        .idEx_i(idExQ), .exMem_i(exMemQ), .memWb_i(memWbQ),
        .takenE_i(takenE), .memStall_i(memStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE),
        .stallM_o(stallM), .stallW_o(stallW),
        .flushD_o(flushD), .flushE_o(flushE), .flushM_o(flushM),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

/* datapathTb.sv */
`timescale 1ns/100ps

module datapathTb;

    localparam int memWords = 1024;

    logic        clk;
    logic        rstN;
    logic        memStall;
    logic [31:0] instAddr, instr, memAddr, memWdata, memRdata;
    logic        instEn, memEn, memWe;
    logic [31:0] wbPc, wbData;
    logic        wbWen;
    logic [4:0]  wbNum;

    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic [31:0] goldMem [memWords];
    logic [31:0] goldReg [32];
    logic [9:0]  progLen;
    logic [31:0] lcgState;

    // expected traces from the ISA model
    logic [31:0] expPc[$];
    logic [4:0]  expNum[$];
    logic [31:0] expData[$];
    logic [31:0] expAddr[$];
    logic [31:0] expWdata[$];
    logic [31:0] skipPcs[$];  // squashed fetches, must never write back

    int wbErrors, storeErrors, otherErrors, cycles, cycleLimit;

    datapath UUT (
        .clk(clk), .rstN_i(rstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata), .memStall_i(memStall),
        .debugWbPc_o(wbPc), .debugWbRfWen_o(wbWen),
        .debugWbRfWnum_o(wbNum), .debugWbRfWdata_o(wbData)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;  // low bits of an LCG are weak
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] idx);
        return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, sa, input logic [5:0] fn);
        return {mipsPkg::opRtype, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen = progLen + 10'd1;
    endtask

    task automatic emitSkipped(input logic [31:0] word);
        skipPcs.push_back({20'h0, progLen, 2'b00});
        emit(word);
    endtask

    // ISA-level model with delay slots
    function automatic void runGolden();
        logic [31:0] pc, npc, nxt, ins, a, b, immS, res, addr;
        logic [4:0]  rs, rt, rd, dst;
        logic        we;
        int          steps;
        for (int i = 0; i < 32; i++) goldReg[i] = 32'h0;
        for (int i = 0; i < memWords; i++) goldMem[i] = fillWord(i);
        pc = mipsPkg::resetPc;
        npc = pc + 32'd4;
        steps = 0;
        while (pc[31:2] < {20'h0, progLen} && steps < 10000) begin
            ins  = imem[pc[11:2]];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            immS = {{16{ins[15]}}, ins[15:0]};
            a    = goldReg[rs];
            b    = goldReg[rt];
            addr = a + immS;
            nxt  = npc + 32'd4;
            we   = 1'b0;
            dst  = rt;
            res  = 32'h0;
            case (ins[31:26])
                mipsPkg::opRtype: begin
                    we  = 1'b1;
                    dst = rd;
                    case (ins[5:0])
                        mipsPkg::fnAddu: res = a + b;
                        mipsPkg::fnSubu: res = a - b;
                        mipsPkg::fnAnd:  res = a & b;
                        mipsPkg::fnOr:   res = a | b;
                        mipsPkg::fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsPkg::fnSll:  res = b << ins[10:6];
                        default:         we = 1'b0;
                    endcase
                end
                mipsPkg::opAddiu: begin we = 1'b1; res = addr; end
                mipsPkg::opLui:   begin we = 1'b1; res = {ins[15:0], 16'h0}; end
                mipsPkg::opLw:    begin we = 1'b1; res = goldMem[addr[11:2]]; end
                mipsPkg::opSw: begin
                    goldMem[addr[11:2]] = b;
                    expAddr.push_back(addr);
                    expWdata.push_back(b);
                end
                mipsPkg::opBeq: if (a == b) nxt = npc + {immS[29:0], 2'b00};
                mipsPkg::opBne: if (a != b) nxt = npc + {immS[29:0], 2'b00};
                mipsPkg::opJ:   nxt = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            if (we && dst != 5'd0) begin
                goldReg[dst] = res;
                expPc.push_back(pc);
                expNum.push_back(dst);
                expData.push_back(res);
            end
            pc  = npc;
            npc = nxt;
            steps++;
        end
    endfunction

    task automatic buildProgram();
        logic [31:0] kind;
        logic [4:0]  rs, rt, rd;
        // dependent alu chain
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd1, 16'h0040));
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'h0005));
        emit(encR(5'd1, 5'd2, 5'd3, 5'd0, mipsPkg::fnAddu));
        emit(encR(5'd3, 5'd2, 5'd4, 5'd0, mipsPkg::fnSubu));
        emit(encR(5'd4, 5'd3, 5'd5, 5'd0, mipsPkg::fnAnd));
        emit(encR(5'd5, 5'd1, 5'd6, 5'd0, mipsPkg::fnOr));
        emit(encR(5'd2, 5'd1, 5'd7, 5'd0, mipsPkg::fnSlt));
        emit(encR(5'd0, 5'd3, 5'd8, 5'd4, mipsPkg::fnSll));
        emit(encI(mipsPkg::opLui, 5'd0, 5'd9, 16'h1234));
        emit(encI(mipsPkg::opAddiu, 5'd9, 5'd9, 16'hFFFF));
        // loads, load-use and stores
        emit(encI(mipsPkg::opLw, 5'd1, 5'd10, 16'h0008));
        emit(encR(5'd10, 5'd2, 5'd11, 5'd0, mipsPkg::fnAddu));
        emit(encI(mipsPkg::opSw, 5'd1, 5'd11, 16'h000C));
        emit(encI(mipsPkg::opLw, 5'd1, 5'd12, 16'h000C));
        emit(encI(mipsPkg::opSw, 5'd1, 5'd12, 16'h0010));
        emit(encI(mipsPkg::opLw, 5'd1, 5'd13, 16'h0010));
        emit(encR(5'd13, 5'd0, 5'd14, 5'd0, mipsPkg::fnSubu));
        // taken beq, then not-taken bne
        emit(encI(mipsPkg::opBeq, 5'd2, 5'd2, 16'd2));
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd15, 16'd1));
        emitSkipped(encI(mipsPkg::opAddiu, 5'd0, 5'd16, 16'd99));
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd17, 16'd7));
        emit(encI(mipsPkg::opBne, 5'd2, 5'd2, 16'd2));
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd18, 16'd3));
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd19, 16'd4));
        // branch on a value still in MEM
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd20, 16'd5));
        emit(encI(mipsPkg::opBeq, 5'd20, 5'd2, 16'd2));
        emit(encI(mipsPkg::opAddiu, 5'd20, 5'd21, 16'd1));
        emitSkipped(encI(mipsPkg::opAddiu, 5'd0, 5'd22, 16'd98));
        // jump over one instruction
        emit({mipsPkg::opJ, 16'h0, progLen + 10'd3});
        emit(encI(mipsPkg::opAddiu, 5'd0, 5'd23, 16'd8));
        emitSkipped(encI(mipsPkg::opAddiu, 5'd0, 5'd24, 16'd97));
        // load feeding a branch
        emit(encI(mipsPkg::opLw, 5'd1, 5'd25, 16'h0008));
        emit(encI(mipsPkg::opBeq, 5'd25, 5'd10, 16'd2));
        emit(encI(mipsPkg::opAddiu, 5'd25, 5'd26, 16'd1));
        emitSkipped(encI(mipsPkg::opAddiu, 5'd0, 5'd27, 16'd96));
        for (int i = 0; i < 40; i++) begin
            kind = nextRand() % 32'd8;
            rs   = 5'(nextRand() & 32'hF);
            rt   = 5'(nextRand() & 32'hF);
            rd   = 5'(nextRand() & 32'hF);
            case (kind[2:0])
                3'd0: emit(encR(rs, rt, rd, 5'd0, mipsPkg::fnAddu));
                3'd1: emit(encR(rs, rt, rd, 5'd0, mipsPkg::fnSubu));
                3'd2: emit(encR(rs, rt, rd, 5'd0, mipsPkg::fnAnd));
                3'd3: emit(encR(rs, rt, rd, 5'd0, mipsPkg::fnOr));
                3'd4: emit(encR(rs, rt, rd, 5'd0, mipsPkg::fnSlt));
                3'd5: emit(encR(5'd0, rt, rd, 5'(nextRand() & 32'h1F), mipsPkg::fnSll));
                3'd6: emit(encI(mipsPkg::opAddiu, rs, rt, 16'(nextRand() & 32'hFFFF)));
                default: emit(encI(mipsPkg::opLui, 5'd0, rt, 16'(nextRand() & 32'hFFFF)));
            endcase
        end
    endtask

    task automatic checkWb(input logic [31:0] pcGot, pcExp, input logic [4:0] numGot, numExp,
                           input logic [31:0] dataGot, dataExp);
        if (pcGot !== pcExp) begin
            $display("CHECK FAILED t=%0t debugWbPc_o got %h exp %h", $time, pcGot, pcExp);
            wbErrors++;
        end
        if (numGot !== numExp) begin
            $display("CHECK FAILED t=%0t debugWbRfWnum_o got %0d exp %0d", $time, numGot, numExp);
            wbErrors++;
        end
        if (dataGot !== dataExp) begin
            $display("CHECK FAILED t=%0t debugWbRfWdata_o got %h exp %h", $time, dataGot, dataExp);
            wbErrors++;
        end
    endtask

    task automatic checkStore(input logic [31:0] addrGot, addrExp, dataGot, dataExp);
        if (addrGot !== addrExp) begin
            $display("CHECK FAILED t=%0t memAddr_o got %h exp %h", $time, addrGot, addrExp);
            storeErrors++;
        end
        if (dataGot !== dataExp) begin
            $display("CHECK FAILED t=%0t memWdata_o got %h exp %h", $time, dataGot, dataExp);
            storeErrors++;
        end
    endtask

    task automatic compareFlag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
            otherErrors++;
        end
    endtask

    // memory models, imem reads nops past the program
    assign instr    = (instAddr[31:2] < {20'h0, progLen}) ? imem[instAddr[11:2]] : 32'h0;
    assign memRdata = dmem[memAddr[11:2]];

    always @(posedge clk) begin
        if (rstN && memWe && !memStall) dmem[memAddr[11:2]] <= memWdata;
    end

    always @(posedge clk) cycles <= cycles + 1;

    always @(negedge clk) begin
        if (cycles > 6) memStall = (nextRand() % 32'd4) == 32'd0;  // about one in four
        else memStall = 1'b0;
    end

    // compare process
    always @(posedge clk) begin
        if (rstN && wbWen) begin
            foreach (skipPcs[k]) begin
                if (wbPc == skipPcs[k]) begin
                    $display("squashed instruction at %h wrote back at t=%0t", wbPc, $time);
                    otherErrors++;
                end
            end
            if (expPc.size() == 0) begin
                $display("unexpected write-back beyond the expected trace at t=%0t", $time);
                otherErrors++;
            end else begin
                checkWb(wbPc, expPc.pop_front(), wbNum, expNum.pop_front(),
                        wbData, expData.pop_front());
            end
        end
        if (rstN && memWe && !memStall) begin
            compareFlag("memEn_o", memEn, 1'b1);
            if (expAddr.size() == 0) begin
                $display("unexpected store beyond the expected trace at t=%0t", $time);
                otherErrors++;
            end else begin
                checkStore(memAddr, expAddr.pop_front(), memWdata, expWdata.pop_front());
            end
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        memStall = 1'b0;
        cycles = 0;
        wbErrors = 0;
        storeErrors = 0;
        otherErrors = 0;
        progLen = 10'd0;
        lcgState = 32'd24;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = 32'h0;
            dmem[i] = fillWord(i);
        end
        buildProgram();
        runGolden();
        cycleLimit = 4 * int'(progLen) + 100;

        // enables sampled between edges while reset is held
        repeat (5) begin
            @(negedge clk);
            compareFlag("debugWbRfWen_o", wbWen, 1'b0);
            compareFlag("memEn_o", memEn, 1'b0);
            compareFlag("memWe_o", memWe, 1'b0);
            compareFlag("instEn_o", instEn, 1'b0);
        end
        rstN = 1'b1;
        if (instAddr !== mipsPkg::resetPc) begin
            $display("CHECK FAILED t=%0t instAddr_o got %h exp %h", $time, instAddr,
                     mipsPkg::resetPc);
            otherErrors++;
        end
        @(negedge clk);
        compareFlag("instEn_o", instEn, 1'b1);
        compareFlag("debugWbRfWen_o", wbWen, 1'b0);
        compareFlag("memWe_o", memWe, 1'b0);

        while ((expPc.size() != 0 || expAddr.size() != 0) && cycles < cycleLimit) @(negedge clk);
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles", cycles);
            otherErrors++;
        end else begin
            repeat (20) @(negedge clk);  // catch late extra write-backs
        end
        if (expPc.size() != 0 || expAddr.size() != 0) begin
            $display("%0d write-backs and %0d stores never seen", expPc.size(), expAddr.size());
            otherErrors++;
        end
        $display("errors: writeback=%0d store=%0d other=%0d", wbErrors, storeErrors, otherErrors);
        if (wbErrors + storeErrors + otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit (
    input  logic           [4:0] rsD_i,
    input  logic           [4:0] rtD_i,
    input  mipsPkg::idExT        idEx_i,
    input  mipsPkg::exMemT       exMem_i,
    input  mipsPkg::memWbT       memWb_i,
    input  logic                 takenE_i,
    input  logic                 memStall_i,
    output logic                 stallF_o,
    output logic                 stallD_o,
    output logic                 stallE_o,
    output logic                 stallM_o,
    output logic                 stallW_o,
    output logic                 flushD_o,
    output logic                 flushE_o,
    output logic                 flushM_o,
    output logic           [1:0] fwdA_o,
    output logic           [1:0] fwdB_o
);

    logic loadUse;

    // 01 from MEM, 10 from WB, 00 keeps the register file value
    function automatic logic [1:0] fwdSel(input logic [4:0] src);
        if (exMem_i.regWe && exMem_i.dst == src) return 2'b01;
        else if (memWb_i.regWe && memWb_i.dst == src) return 2'b10;
        else return 2'b00;
    endfunction

    assign fwdA_o = fwdSel(idEx_i.rs);
    assign fwdB_o = fwdSel(idEx_i.rt);

    // load in EX feeding the instruction in ID
    assign loadUse = idEx_i.memRe && idEx_i.dst != 5'd0
                     && (idEx_i.dst == rsD_i || idEx_i.dst == rtD_i);

    assign stallF_o = loadUse | memStall_i;
    assign stallD_o = loadUse | memStall_i;
    assign stallE_o = memStall_i;
    assign stallM_o = memStall_i;
    assign stallW_o = memStall_i;

    // kill the fetch after the delay slot
    assign flushD_o = takenE_i & ~memStall_i;
    // bubble where a stage holds and the next one moves on
    assign flushE_o = stallD_o & ~stallE_o;
    assign flushM_o = stallE_o & ~stallM_o;

endmodule

/* mainDecoder.sv */
`timescale 1ns/100ps

module mainDecoder (
    input  logic [31:0]    instr_i,
    input  logic [31:0]    pcPlus4_i,
    output mipsPkg::aluOpT aluOp_o,
    output logic           aluImm_o,
    output logic           signExt_o,
    output logic           regWe_o,
    output logic           memRe_o,
    output logic           memWe_o,
    output logic           isBeq_o,
    output logic           isBne_o,
    output logic           isJump_o,
    output logic           dstRt_o,
    output logic [31:0]    jumpTarget_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    // j stays inside the 256MB region of the delay slot
    assign jumpTarget_o = {pcPlus4_i[31:28], instr_i[25:0], 2'b00};

    always_comb begin
        aluOp_o   = mipsPkg::aluAdd;
        aluImm_o  = 1'b0;
        signExt_o = 1'b0;
        regWe_o   = 1'b0;
        memRe_o   = 1'b0;
        memWe_o   = 1'b0;
        isBeq_o   = 1'b0;
        isBne_o   = 1'b0;
        isJump_o  = 1'b0;
        dstRt_o   = 1'b0;
        case (opcode)
            mipsPkg::opRtype: begin
                regWe_o = 1'b1;  // rd destination
                case (funct)
                    mipsPkg::fnAddu: aluOp_o = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp_o = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp_o = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp_o = mipsPkg::aluOr;
                    mipsPkg::fnSlt:  aluOp_o = mipsPkg::aluSlt;
                    mipsPkg::fnSll:  aluOp_o = mipsPkg::aluSll;
                    default:         regWe_o = 1'b0;  // unsupported funct is a nop
                endcase
            end
            mipsPkg::opAddiu: begin
                aluImm_o  = 1'b1;
                signExt_o = 1'b1;
                regWe_o   = 1'b1;
                dstRt_o   = 1'b1;
            end
            mipsPkg::opLui: begin
                aluOp_o  = mipsPkg::aluPassB;
                aluImm_o = 1'b1;
                regWe_o  = 1'b1;
                dstRt_o  = 1'b1;
            end
            mipsPkg::opLw: begin
                aluImm_o  = 1'b1;
                signExt_o = 1'b1;
                regWe_o   = 1'b1;
                memRe_o   = 1'b1;
                dstRt_o   = 1'b1;
            end
            mipsPkg::opSw: begin
                aluImm_o  = 1'b1;
                signExt_o = 1'b1;
                memWe_o   = 1'b1;
            end
            mipsPkg::opBeq: begin
                signExt_o = 1'b1;
                isBeq_o   = 1'b1;
            end
            mipsPkg::opBne: begin
                signExt_o = 1'b1;
                isBne_o   = 1'b1;
            end
            mipsPkg::opJ: isJump_o = 1'b1;
            default: ;  // unknown opcode, all enables stay low
        endcase
    end

endmodule

/* mipsPkg.sv */
package mipsPkg;

    // opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // funct field of r-type
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam logic [31:0] resetPc = 32'h0000_0000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluPassB  // lui, imm already shifted in ID
    } aluOpT;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [31:0] branchTarget;
        logic [4:0]  sa;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        aluOpT       aluOp;
        logic        aluImm;
        logic        regWe;
        logic        memRe;
        logic        memWe;
        logic        isBeq;
        logic        isBne;
    } idExT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] storeData;
        logic [4:0]  dst;
        logic        regWe;
        logic        memRe;
        logic        memWe;
    } exMemT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dst;
        logic        regWe;
    } memWbT;

endpackage

/* pipeReg.sv */
`timescale 1ns/100ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // flush turns the stage into a bubble, even while stalled
    always_ff @(posedge clk) begin
        if (!rstN_i || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        we_i,
    input  logic [4:0]  ra1_i,
    input  logic [4:0]  ra2_i,
    input  logic [4:0]  wa_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != 5'd0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // write-first, so WB and ID see the same value in one cycle
    always_comb begin
        if (ra1_i == 5'd0) rd1_o = 32'h0;
        else if (we_i && wa_i == ra1_i) rd1_o = wd_i;
        else rd1_o = regs[ra1_i];

        if (ra2_i == 5'd0) rd2_o = 32'h0;
        else if (we_i && wa_i == ra2_i) rd2_o = wd_i;
        else rd2_o = regs[ra2_i];
    end

endmodule

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module datapathTb -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "^Test passed$"

/* src.f */
mipsPkg.sv
pipeReg.sv
regFile.sv
mainDecoder.sv
alu.sv
hazardUnit.sv
datapath.sv
datapathTb.sv
